/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
  -f tb.f --Mdir obj_dir -o tb_sim

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi

/* tb.f */
+incdir+verif
verilog/rp_io_pkg.sv
verilog/rp_reset_seq.sv
verilog/rp_adc_frontend.sv
verilog/rp_dac_backend.sv
verilog/rp_exp_pin_mux.sv
verilog/rp_io_top.sv
verif/tb_top.sv

/* verif/rp_io_ref.svh */
/*
 * Reference model for the converter I/O top level
 *  - ADC neg-slope to two's complement conversion
 *  - DAC sum with clipping, and DAC pin encoding
 *  - Expansion pin mux outputs and input taps
 */

`ifndef RP_IO_REF_SVH
`define RP_IO_REF_SVH

// Flip all bits except the sign
function automatic logic [15:0] adc_conv(input logic [15:0] raw);
  return raw ^ 16'h7fff;
endfunction

// Full-precision sum, clipped to the 14-bit range
function automatic logic [13:0] dac_sat(input logic signed [13:0] a,
                                        input logic signed [13:0] b);
  int sum;
  sum = int'(a) + int'(b);
  if (sum > 8191)
    sum = 8191;
  else if (sum < -8192)
    sum = -8192;
  return sum[13:0];
endfunction

function automatic logic [13:0] dac_encode(input logic [13:0] smp);
  return smp ^ 14'h1fff;  // Sign kept, magnitude bits inverted
endfunction

// Expected pin mux outputs for one set of inputs
function automatic void pin_mux(
  input  logic [EXP_W-1:0] p_in,
  input  logic [EXP_W-1:0] gp_p_out,
  input  logic [EXP_W-1:0] gp_p_dir,
  input  logic [EXP_W-1:0] gp_n_out,
  input  logic [EXP_W-1:0] gp_n_dir,
  input  daisy_mode_t      dm,
  input  logic             can_on,
  input  logic             can0_tx,
  input  logic             can1_tx,
  input  logic             scope_trig,
  input  logic             asg_trig,
  input  logic             daisy_trig,
  output logic [EXP_W-1:0] p_o,
  output logic [EXP_W-1:0] p_oe,
  output logic [EXP_W-1:0] n_o,
  output logic [EXP_W-1:0] n_oe,
  output logic             trig,
  output logic             rx0,
  output logic             rx1
);
  p_o  = gp_p_out;  // P side never overlaid
  p_oe = gp_p_dir;
  n_o  = gp_n_out;
  n_oe = gp_n_dir;
  if (dm[DM_TRIG_OUT]) begin
    n_o[TRIG_PIN]  = dm[DM_TRIG_SEL] ? asg_trig : scope_trig;
    n_oe[TRIG_PIN] = 1'b1;
  end
  if (can_on) begin
    n_o[CAN0_PIN]  = can0_tx;
    n_oe[CAN0_PIN] = 1'b1;
    n_o[CAN1_PIN]  = can1_tx;
    n_oe[CAN1_PIN] = 1'b1;
  end
  trig = (dm[DM_SYNC] && daisy_trig) ? 1'b0 : p_in[TRIG_PIN];
  rx0  = can_on ? p_in[CAN0_PIN] : 1'b0;
  rx1  = can_on ? p_in[CAN1_PIN] : 1'b0;
endfunction

`endif

/* verif/tb_top.sv */
/*
 * Testbench for the converter I/O top level
 *  - Clock, reset and PLL lock sequencing
 *  - Random ADC, DAC, loopback and pin mux stimulus
 *  - Comparison process against the reference model
 *  - Cycle-count timeout
 */

`timescale 1ns/1ps

module tb_top;

  import rp_io_pkg::*;

  localparam int RST_MAX     = 64;
  localparam int EXP_W       = 11;
  localparam int TIMEOUT_CYC = 3000;  // Test sequence is about 880 cycles

  localparam logic [13:0] DAC_MAX = 14'h1fff;
  localparam logic [13:0] DAC_MIN = 14'h2000;

  `include "rp_io_ref.svh"

  logic adc_clk = 1'b0;
  logic rst_i, pll_locked_i, digital_loop_i, dac_rst_o;
  adc_raw_t  adc_dat_a_i, adc_dat_b_i;
  adc_smp_t  adc_a_o, adc_b_o;
  dac_smp_t  asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  logic [EXP_W-1:0] exp_p_in_i, exp_n_in_i, gp_p_out_i, gp_p_dir_i, gp_n_out_i, gp_n_dir_i;
  logic [EXP_W-1:0] exp_p_o, exp_p_oe_o, exp_n_o, exp_n_oe_o;
  daisy_mode_t daisy_mode_i;
  logic can_on_i, can0_tx_i, can1_tx_i, scope_trig_i, asg_trig_i, daisy_trig_i;
  logic trig_ext_o, can0_rx_o, can1_rx_o;

  int   err_cnt   = 0;
  int   chk_cnt   = 0;
  int   tests_run = 0;
  int   cyc       = 0;
  logic chk_adc   = 1'b0;  // Compare ADC outputs
  logic chk_dac   = 1'b0;
  logic chk_mux   = 1'b0;
  logic adc_pend  = 1'b0;  // Expectation from last cycle is valid
  logic dac_pend  = 1'b0;
  adc_smp_t  want_adc_a, want_adc_b;
  dac_code_t want_dac_a, want_dac_b;

  rp_io_top #(.RST_MAX (RST_MAX), .EXP_W (EXP_W)) dut (.*);

  always #10 adc_clk = ~adc_clk;  // 20 ns period

  ////////////////////////////////////////
  // Check, drive and report helpers
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("FAILED %0t: %s got %0h expected %0h", $time, what, got, want);
    end
  endtask

  task automatic next_cycle();
    @(posedge adc_clk);
    #2;  // Drive point
  endtask

  // Cycles from first lock-high edge until dac_rst_o drops
  task automatic measure_release(output int n);
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (dac_rst_o && n < RST_MAX + 20);
  endtask

  task automatic drive_dac(input logic [13:0] aa, input logic [13:0] pa,
                           input logic [13:0] ab, input logic [13:0] pb);
    next_cycle();
    asg_a_i = aa;
    pid_a_i = pa;
    asg_b_i = ab;
    pid_b_i = pb;
  endtask

  // Let the last one-cycle expectation be compared
  task automatic drain_checks();
    next_cycle();
    chk_adc = 1'b0;
    chk_dac = 1'b0;
    chk_mux = 1'b0;
    next_cycle();
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    $display("test %-10s %0d mismatches", name, err_cnt - errs_before);
  endtask

  ////////////////////////////////////////
  // Comparison process
  ////////////////////////////////////////

  always @(negedge adc_clk) begin
    logic [EXP_W-1:0] p_o, p_oe, n_o, n_oe;
    logic             trig, rx0, rx1;
    if (adc_pend) begin
      check_value("adc_a_o", adc_a_o, want_adc_a);
      check_value("adc_b_o", adc_b_o, want_adc_b);
    end
    if (dac_pend) begin
      check_value("dac_dat_a_o", dac_dat_a_o, want_dac_a);
      check_value("dac_dat_b_o", dac_dat_b_o, want_dac_b);
    end
    if (chk_mux) begin  // Combinational, same cycle
      pin_mux(exp_p_in_i, gp_p_out_i, gp_p_dir_i, gp_n_out_i, gp_n_dir_i, daisy_mode_i,
              can_on_i, can0_tx_i, can1_tx_i, scope_trig_i, asg_trig_i, daisy_trig_i,
              p_o, p_oe, n_o, n_oe, trig, rx0, rx1);
      check_value("exp_p_o", exp_p_o, p_o);
      check_value("exp_p_oe_o", exp_p_oe_o, p_oe);
      check_value("exp_n_o", exp_n_o, n_o);
      check_value("exp_n_oe_o", exp_n_oe_o, n_oe);
      check_value("trig_ext_o", trig_ext_o, trig);
      check_value("can0_rx_o", can0_rx_o, rx0);
      check_value("can1_rx_o", can1_rx_o, rx1);
    end
    // Expectations for the registers loaded at the next edge
    adc_pend   = chk_adc;
    dac_pend   = chk_dac;
    want_dac_a = dac_rst_o ? '0 : dac_encode(dac_sat(asg_a_i, pid_a_i));
    want_dac_b = dac_rst_o ? '0 : dac_encode(dac_sat(asg_b_i, pid_b_i));
    if (dac_rst_o) begin
      want_adc_a = '0;
      want_adc_b = '0;
    end else if (digital_loop_i) begin
      want_adc_a = {2'b00, dac_sat(asg_a_i, pid_a_i)};
      want_adc_b = {2'b00, dac_sat(asg_b_i, pid_b_i)};
    end else begin
      want_adc_a = adc_conv(adc_dat_a_i);
      want_adc_b = adc_conv(adc_dat_b_i);
    end
  end

  always @(posedge adc_clk) begin
    cyc++;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: test sequence still running after %0d cycles", cyc);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int n;
    int errs;
    void'($urandom(6513));
    rst_i = 1'b1;
    pll_locked_i = 1'b0;
    digital_loop_i = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    asg_a_i = '0;
    asg_b_i = '0;
    pid_a_i = '0;
    pid_b_i = '0;
    exp_p_in_i = '0;
    exp_n_in_i = '0;
    gp_p_out_i = '0;
    gp_p_dir_i = '0;
    gp_n_out_i = '0;
    gp_n_dir_i = '0;
    daisy_mode_i = '0;
    {can_on_i, can0_tx_i, can1_tx_i} = '0;
    {scope_trig_i, asg_trig_i, daisy_trig_i} = '0;
    repeat (10) @(posedge adc_clk);
    #2 rst_i = 1'b0;

    // Lock after reset, then a one-cycle lock loss
    errs = err_cnt;
    repeat (3) begin
      next_cycle();
      check_value("dac_rst_o without lock", dac_rst_o, 1);
    end
    pll_locked_i = 1'b1;
    measure_release(n);
    check_value("release delay after lock", n, RST_MAX + 2);
    repeat (5) begin
      next_cycle();
      check_value("dac_rst_o while locked", dac_rst_o, 0);
    end
    pll_locked_i = 1'b0;
    next_cycle();
    check_value("dac_rst_o after lock loss", dac_rst_o, 1);
    pll_locked_i = 1'b1;
    measure_release(n);
    check_value("release delay after relock", n, RST_MAX + 2);
    report_test("reset_seq", errs);

    errs = err_cnt;
    chk_adc = 1'b1;
    repeat (200) begin
      next_cycle();
      adc_dat_a_i = 16'($urandom);
      adc_dat_b_i = 16'($urandom);
    end
    drain_checks();
    report_test("adc_conv", errs);

    errs = err_cnt;
    chk_dac = 1'b1;
    repeat (200)
      drive_dac(14'($urandom), 14'($urandom), 14'($urandom), 14'($urandom));
    drive_dac(DAC_MAX, DAC_MAX, DAC_MIN, DAC_MIN);
    drive_dac(DAC_MIN, DAC_MIN, DAC_MAX, DAC_MAX);
    drive_dac(DAC_MAX, DAC_MIN, DAC_MIN, DAC_MAX);
    drain_checks();
    report_test("dac_sat", errs);

    // Raw pins keep toggling, loopback must ignore them
    errs = err_cnt;
    digital_loop_i = 1'b1;
    chk_adc = 1'b1;
    chk_dac = 1'b1;
    repeat (100) begin
      drive_dac(14'($urandom), 14'($urandom), 14'($urandom), 14'($urandom));
      adc_dat_a_i = 16'($urandom);
      adc_dat_b_i = 16'($urandom);
    end
    drive_dac(DAC_MAX, DAC_MAX, DAC_MIN, DAC_MIN);
    drive_dac(DAC_MAX, DAC_MIN, DAC_MIN, DAC_MIN);
    drain_checks();
    digital_loop_i = 1'b0;
    report_test("loopback", errs);

    errs = err_cnt;
    chk_mux = 1'b1;
    repeat (200) begin
      next_cycle();
      exp_p_in_i   = EXP_W'($urandom);
      exp_n_in_i   = EXP_W'($urandom);
      gp_p_out_i   = EXP_W'($urandom);
      gp_p_dir_i   = EXP_W'($urandom);
      gp_n_out_i   = EXP_W'($urandom);
      gp_n_dir_i   = EXP_W'($urandom);
      daisy_mode_i = 3'($urandom);
      {can_on_i, can0_tx_i, can1_tx_i} = 3'($urandom);
      {scope_trig_i, asg_trig_i, daisy_trig_i} = 3'($urandom);
    end
    drain_checks();
    report_test("pin_mux", errs);

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule : tb_top

/* verilog/rp_adc_frontend.sv */
/*
 * ADC front end for two channels
 *  - Neg-slope to two's complement conversion
 *  - Digital loopback of the saturated DAC samples
 *  - Output register, cleared by converter reset
 */

`timescale 1ns/1ps

module rp_adc_frontend (
  input  logic               adc_clk,
  input  logic               rst_i,        // Converter reset
  input  rp_io_pkg::adc_raw_t adc_raw_a_i, // Raw pins, channel A
  input  rp_io_pkg::adc_raw_t adc_raw_b_i, // Raw pins, channel B
  input  logic               loop_en_i,    // Take DAC path instead of pins
  input  rp_io_pkg::dac_smp_t loop_a_i,
  input  rp_io_pkg::dac_smp_t loop_b_i,
  output rp_io_pkg::adc_smp_t adc_a_o,
  output rp_io_pkg::adc_smp_t adc_b_o
);

  import rp_io_pkg::*;

  ////////////////////////////////////////
  // Per-channel conversion
  ////////////////////////////////////////

  // Same map for both channels
  function automatic adc_smp_t adc_conv(
    input adc_raw_t raw,
    input logic     loop_en,
    input dac_smp_t loop
  );
    if (loop_en)
      return {2'b00, loop};  // Loop sample, top two bits zero
    // MSB kept, rest inverted
    return {raw[$bits(adc_raw_t)-1], ~raw[$bits(adc_raw_t)-2:0]};
  endfunction

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= adc_conv(adc_raw_a_i, loop_en_i, loop_a_i);  // CH A
      adc_b_o <= adc_conv(adc_raw_b_i, loop_en_i, loop_b_i);  // CH B
    end
  end

endmodule : rp_adc_frontend

/* verilog/rp_dac_backend.sv */
/*
 * DAC back end for two channels
 *  - Generator plus controller sum
 *  - Saturation to 14 bits, exported for loopback
 *  - Neg-slope encoding into registered DAC codes
 */

`timescale 1ns/1ps

module rp_dac_backend (
  input  logic                adc_clk,
  input  logic                rst_i,         // Converter reset
  input  rp_io_pkg::dac_smp_t asg_a_i,       // Generator samples
  input  rp_io_pkg::dac_smp_t asg_b_i,
  input  rp_io_pkg::dac_smp_t pid_a_i,       // Controller samples
  input  rp_io_pkg::dac_smp_t pid_b_i,
  output rp_io_pkg::dac_smp_t sat_a_o,       // Saturated, combinational
  output rp_io_pkg::dac_smp_t sat_b_o,
  output rp_io_pkg::dac_code_t dac_code_a_o, // Registered pin codes
  output rp_io_pkg::dac_code_t dac_code_b_o
);

  import rp_io_pkg::*;

  dac_sum_t sum_a;
  dac_sum_t sum_b;

  ////////////////////////////////////////
  // Saturation and encoding
  ////////////////////////////////////////

  // Top two sum bits differ means overflow, clip by sign
  function automatic dac_smp_t dac_sat(input dac_sum_t sum);
    if (sum[14] ^ sum[13])
      return {sum[14], {13{~sum[14]}}};
    return sum[13:0];
  endfunction

  // Signed to neg-slope offset code
  function automatic dac_code_t dac_encode(input dac_smp_t smp);
    return {smp[13], ~smp[12:0]};
  endfunction

  assign sum_a = asg_a_i + pid_a_i;  // Sign-extended to 15 bits
  assign sum_b = asg_b_i + pid_b_i;

  assign sat_a_o = dac_sat(sum_a);
  assign sat_b_o = dac_sat(sum_b);

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_code_a_o <= '0;
      dac_code_b_o <= '0;
    end else begin
      dac_code_a_o <= dac_encode(sat_a_o);
      dac_code_b_o <= dac_encode(sat_b_o);
    end
  end

  // In-range sum reaches the pins unclipped one cycle later
  a_sum_pass_a : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !(sum_a[14] ^ sum_a[13]) |=> dac_code_a_o == dac_encode($past(sum_a[13:0]))
  ) else $error("channel A in-range sum altered on its way to the DAC");

  a_sum_pass_b : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !(sum_b[14] ^ sum_b[13]) |=> dac_code_b_o == dac_encode($past(sum_b[13:0]))
  ) else $error("channel B in-range sum altered on its way to the DAC");

endmodule : rp_dac_backend

/* verilog/rp_exp_pin_mux.sv */
/*
 * Expansion connector pin mux
 *  - Trigger output and CAN transmit overlays on the n side
 *  - General-purpose pass-through for all other pins
 *  - External trigger and CAN receive taps from the p side
 */

`timescale 1ns/1ps

module rp_exp_pin_mux #(
  parameter int unsigned EXP_W = 11  // Pins per side, 8 or more
)(
  input  logic [EXP_W-1:0]       exp_p_in_i,   // Pin readback, p side
  input  logic [EXP_W-1:0]       exp_n_in_i,   // Pin readback, n side
  input  logic [EXP_W-1:0]       gp_p_out_i,   // Housekeeping GPIO
  input  logic [EXP_W-1:0]       gp_p_dir_i,   // 1 = output
  input  logic [EXP_W-1:0]       gp_n_out_i,
  input  logic [EXP_W-1:0]       gp_n_dir_i,
  input  rp_io_pkg::daisy_mode_t daisy_mode_i,
  input  logic                   can_on_i,     // CAN owns pins 6/7
  input  logic                   can0_tx_i,
  input  logic                   can1_tx_i,
  input  logic                   scope_trig_i,
  input  logic                   asg_trig_i,
  input  logic                   daisy_trig_i, // Trigger bit from daisy link
  output logic [EXP_W-1:0]       exp_p_o,
  output logic [EXP_W-1:0]       exp_p_oe_o,
  output logic [EXP_W-1:0]       exp_n_o,
  output logic [EXP_W-1:0]       exp_n_oe_o,
  output logic                   trig_ext_o,
  output logic                   can0_rx_o,
  output logic                   can1_rx_o
);

  import rp_io_pkg::*;

  logic             trig_sel;   // Trigger chosen for output
  logic [EXP_W-1:0] n_alt;      // Pin taken by alternate function
  logic [EXP_W-1:0] n_alt_dat;  // Alternate function data

  assign trig_sel = daisy_mode_i[DM_TRIG_SEL] ? asg_trig_i : scope_trig_i;

  ////////////////////////////////////////
  // N side overlay
  ////////////////////////////////////////

  always_comb begin
    n_alt     = '0;
    n_alt_dat = '0;
    n_alt[TRIG_PIN]     = daisy_mode_i[DM_TRIG_OUT];
    n_alt_dat[TRIG_PIN] = trig_sel;
    n_alt[CAN0_PIN]     = can_on_i;
    n_alt_dat[CAN0_PIN] = can0_tx_i;
    n_alt[CAN1_PIN]     = can_on_i;
    n_alt_dat[CAN1_PIN] = can1_tx_i;

    exp_n_o    = (n_alt & n_alt_dat) | (~n_alt & gp_n_out_i);
    exp_n_oe_o = n_alt | gp_n_dir_i;  // Alternate functions always drive

    // Trigger and CAN pins must never float while their function is on
    if (!$isunknown({daisy_mode_i[DM_TRIG_OUT], can_on_i}))
      a_alt_driven : assert (
        (!daisy_mode_i[DM_TRIG_OUT] || exp_n_oe_o[TRIG_PIN]) &&
        (!can_on_i || (exp_n_oe_o[CAN0_PIN] && exp_n_oe_o[CAN1_PIN]))
      ) else $error("overridden n-side pin without output enable");
  end

  // P side has no alternate functions
  assign exp_p_o    = gp_p_out_i;
  assign exp_p_oe_o = gp_p_dir_i;

  ////////////////////////////////////////
  // Input taps
  ////////////////////////////////////////

  // Daisy sync owns the trigger while its own bit is set
  assign trig_ext_o = exp_p_in_i[TRIG_PIN] & ~(daisy_mode_i[DM_SYNC] & daisy_trig_i);

  assign can0_rx_o = can_on_i & exp_p_in_i[CAN0_PIN];
  assign can1_rx_o = can_on_i & exp_p_in_i[CAN1_PIN];
  // exp_n_in_i is read back by housekeeping only, no tap here

endmodule : rp_exp_pin_mux

/* verilog/rp_io_pkg.sv */
/*
 * Shared definitions for the two-channel converter I/O top level
 *  - ADC raw and two's complement sample types
 *  - DAC sample, sum and pin code types
 *  - Reset sequencer state encoding
 *  - Daisy mode bit positions and expansion pin indices
 */

package rp_io_pkg;

  ////////////////////////////////////////
  // Sample types
  ////////////////////////////////////////

  typedef logic        [16-1:0] adc_raw_t;   // Neg-slope word from ADC pins
  typedef logic signed [16-1:0] adc_smp_t;   // Two's complement ADC sample
  typedef logic signed [14-1:0] dac_smp_t;   // Generator/controller sample
  typedef logic signed [15-1:0] dac_sum_t;   // Sum before saturation
  typedef logic        [14-1:0] dac_code_t;  // Neg-slope code to DAC pins

  ////////////////////////////////////////
  // Reset sequencer
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    RST_WAIT_LOCK = 2'd0,  // Waiting for PLL lock edge
    RST_HOLD      = 2'd1,  // Counting hold time
    RST_RUN       = 2'd2   // Converters out of reset
  } rst_state_t;

  ////////////////////////////////////////
  // Daisy mode and expansion pins
  ////////////////////////////////////////

  typedef logic [3-1:0] daisy_mode_t;

  localparam int unsigned DM_SYNC     = 0;  // Sync mode, masks ext trigger
  localparam int unsigned DM_TRIG_OUT = 1;  // Trigger out on n-side pin
  localparam int unsigned DM_TRIG_SEL = 2;  // 1 = generator, 0 = scope trigger

  // Pin positions on the expansion connector
  localparam int unsigned TRIG_PIN = 0;
  localparam int unsigned CAN1_PIN = 6;
  localparam int unsigned CAN0_PIN = 7;

endpackage : rp_io_pkg

/* verilog/rp_io_top.sv */
/*
 * Converter I/O top level
 *  - Reset sequencer driving converter and DAC reset
 *  - ADC front end with digital loopback
 *  - DAC back end with saturation and encoding
 *  - Expansion connector pin mux
 */

`timescale 1ns/1ps

module rp_io_top #(
  parameter int unsigned RST_MAX = 64,  // Hold cycles after PLL lock
  parameter int unsigned EXP_W   = 11   // Expansion pins per side
)(
  input  logic                   adc_clk,
  input  logic                   rst_i,
  input  logic                   pll_locked_i,
  input  logic                   digital_loop_i,  // DAC to ADC loopback
  // ADC
  input  rp_io_pkg::adc_raw_t    adc_dat_a_i,
  input  rp_io_pkg::adc_raw_t    adc_dat_b_i,
  output rp_io_pkg::adc_smp_t    adc_a_o,
  output rp_io_pkg::adc_smp_t    adc_b_o,
  // DAC
  input  rp_io_pkg::dac_smp_t    asg_a_i,
  input  rp_io_pkg::dac_smp_t    asg_b_i,
  input  rp_io_pkg::dac_smp_t    pid_a_i,
  input  rp_io_pkg::dac_smp_t    pid_b_i,
  output rp_io_pkg::dac_code_t   dac_dat_a_o,
  output rp_io_pkg::dac_code_t   dac_dat_b_o,
  output logic                   dac_rst_o,
  // Expansion connector
  input  logic [EXP_W-1:0]       exp_p_in_i,
  input  logic [EXP_W-1:0]       exp_n_in_i,
  input  logic [EXP_W-1:0]       gp_p_out_i,
  input  logic [EXP_W-1:0]       gp_p_dir_i,
  input  logic [EXP_W-1:0]       gp_n_out_i,
  input  logic [EXP_W-1:0]       gp_n_dir_i,
  input  rp_io_pkg::daisy_mode_t daisy_mode_i,
  input  logic                   can_on_i,
  input  logic                   can0_tx_i,
  input  logic                   can1_tx_i,
  input  logic                   scope_trig_i,
  input  logic                   asg_trig_i,
  input  logic                   daisy_trig_i,
  output logic [EXP_W-1:0]       exp_p_o,
  output logic [EXP_W-1:0]       exp_p_oe_o,
  output logic [EXP_W-1:0]       exp_n_o,
  output logic [EXP_W-1:0]       exp_n_oe_o,
  output logic                   trig_ext_o,
  output logic                   can0_rx_o,
  output logic                   can1_rx_o
);

  import rp_io_pkg::*;

  logic     conv_rst;   // Shared converter reset
  dac_smp_t dac_sat_a;  // Saturated DAC values for loopback
  dac_smp_t dac_sat_b;

  ////////////////////////////////////////
  // Reset and converters
  ////////////////////////////////////////

  rp_reset_seq #(.RST_MAX (RST_MAX)) i_reset_seq (
    .adc_clk      (adc_clk     ),
    .rst_i        (rst_i       ),
    .pll_locked_i (pll_locked_i),
    .conv_rst_o   (conv_rst    )
  );

  assign dac_rst_o = conv_rst;  // DAC chip reset follows the sequencer

  rp_adc_frontend i_adc (
    .adc_clk     (adc_clk       ),
    .rst_i       (conv_rst      ),
    .adc_raw_a_i (adc_dat_a_i   ),
    .adc_raw_b_i (adc_dat_b_i   ),
    .loop_en_i   (digital_loop_i),
    .loop_a_i    (dac_sat_a     ),
    .loop_b_i    (dac_sat_b     ),
    .adc_a_o     (adc_a_o       ),
    .adc_b_o     (adc_b_o       )
  );

  rp_dac_backend i_dac (
    .adc_clk      (adc_clk    ),
    .rst_i        (conv_rst   ),
    .asg_a_i      (asg_a_i    ),
    .asg_b_i      (asg_b_i    ),
    .pid_a_i      (pid_a_i    ),
    .pid_b_i      (pid_b_i    ),
    .sat_a_o      (dac_sat_a  ),
    .sat_b_o      (dac_sat_b  ),
    .dac_code_a_o (dac_dat_a_o),
    .dac_code_b_o (dac_dat_b_o)
  );

  ////////////////////////////////////////
  // Expansion connector
  ////////////////////////////////////////

  rp_exp_pin_mux #(.EXP_W (EXP_W)) i_exp_mux (
    .exp_p_in_i   (exp_p_in_i  ),
    .exp_n_in_i   (exp_n_in_i  ),
    .gp_p_out_i   (gp_p_out_i  ),
    .gp_p_dir_i   (gp_p_dir_i  ),
    .gp_n_out_i   (gp_n_out_i  ),
    .gp_n_dir_i   (gp_n_dir_i  ),
    .daisy_mode_i (daisy_mode_i),
    .can_on_i     (can_on_i    ),
    .can0_tx_i    (can0_tx_i   ),
    .can1_tx_i    (can1_tx_i   ),
    .scope_trig_i (scope_trig_i),
    .asg_trig_i   (asg_trig_i  ),
    .daisy_trig_i (daisy_trig_i),
    .exp_p_o      (exp_p_o     ),
    .exp_p_oe_o   (exp_p_oe_o  ),
    .exp_n_o      (exp_n_o     ),
    .exp_n_oe_o   (exp_n_oe_o  ),
    .trig_ext_o   (trig_ext_o  ),
    .can0_rx_o    (can0_rx_o   ),
    .can1_rx_o    (can1_rx_o   )
  );

endmodule : rp_io_top

/* verilog/rp_reset_seq.sv */
/*
 * Converter reset sequencer
 *  - PLL lock edge detector
 *  - Wait / hold / run FSM with hold counter
 *  - Registered converter reset output
 */

`timescale 1ns/1ps

module rp_reset_seq #(
  parameter int unsigned RST_MAX = 64  // Hold length after lock edge
)(
  input  logic adc_clk,
  input  logic rst_i,         // Sync, active high
  input  logic pll_locked_i,  // Sampling PLL status
  output logic conv_rst_o     // Converter reset, active high
);

  import rp_io_pkg::*;

  // Hold counter runs 0 to RST_MAX-1
  localparam int unsigned CNT_W = $clog2(RST_MAX + 1);

  rst_state_t       state;
  logic             lock_prev;  // Lock as seen one cycle ago
  logic [CNT_W-1:0] hold_cnt;

  ////////////////////////////////////////
  // FSM and hold counter
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state      <= RST_WAIT_LOCK;
      lock_prev  <= 1'b0;  // Lock already high counts as an edge
      hold_cnt   <= '0;
      conv_rst_o <= 1'b1;
    end else begin
      lock_prev  <= pll_locked_i;
      // Lost lock raises reset on the same edge as the FSM falls back
      conv_rst_o <= (state != RST_RUN) | ~pll_locked_i;

      if (!pll_locked_i) begin  // Lock loss from any state
        state    <= RST_WAIT_LOCK;
        hold_cnt <= '0;
      end else begin
        case (state)
          RST_WAIT_LOCK: begin
            if (!lock_prev) begin  // Rising edge of lock
              state    <= RST_HOLD;
              hold_cnt <= '0;
            end
          end
          RST_HOLD: begin
            if (hold_cnt == CNT_W'(RST_MAX - 1))  // RST_MAX cycles in hold
              state <= RST_RUN;
            else
              hold_cnt <= hold_cnt + 1'b1;
          end
          RST_RUN: ;  // Stay until lock drops
          default: state <= RST_WAIT_LOCK;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Converters never leave reset before the FSM reaches run
  a_rst_until_run : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    (state != RST_RUN) |-> conv_rst_o
  ) else $error("converter reset low while FSM not in run");

endmodule : rp_reset_seq
